//--- source/AxiLiteRegPkg.sv
`default_nettype none

package AxiLiteRegPkg;

    // Byte address width. Eight bits reach 64 words.
    localparam int AddrWidth = 8;
    localparam int DataWidth = 32;
    localparam int StrbWidth = DataWidth / 8;

    // AXI response codes used by this slave.
    typedef enum logic [1:0] {
        Okay   = 2'b00,
        SlvErr = 2'b10
    } Resp_t;

    // Identification word returned by register 0.
    localparam logic [DataWidth-1:0] IdValue = 32'hA11E_5201;

    // Write request to the register bank, word addressed.
    typedef struct packed {
        logic [AddrWidth-1:0] wordAddr;
        logic [DataWidth-1:0] data;
        logic [StrbWidth-1:0] strobe;
    } WriteReq_t;

    // Read answer from the register bank.
    typedef struct packed {
        logic [DataWidth-1:0] data;
        Resp_t                resp;
    } ReadRsp_t;

endpackage

`default_nettype wire

//--- source/AxiLiteWriteChannel.sv
`timescale 1ns/1ns
`default_nettype none

module AxiLiteWriteChannel (
    input  wire logic                                   ACLK,
    input  wire logic                                   ARESETN,
    input  wire logic                                   AWVALID,
    output logic                                        AWREADY,
    input  wire logic [AxiLiteRegPkg::AddrWidth-1:0]    AWADDR,
    input  wire logic [2:0]                             AWPROT,
    input  wire logic                                   WVALID,
    output logic                                        WREADY,
    input  wire logic [AxiLiteRegPkg::DataWidth-1:0]    WDATA,
    input  wire logic [AxiLiteRegPkg::StrbWidth-1:0]    WSTRB,
    output logic                                        BVALID,
    input  wire logic                                   BREADY,
    output logic [1:0]                                  BRESP,
    output AxiLiteRegPkg::WriteReq_t                    writeReq,
    output logic                                        writeValid,
    input  wire logic                                   writeAck,
    input  wire AxiLiteRegPkg::Resp_t                   writeResp
);

    typedef enum logic [1:0] {
        Idle,
        Request,
        Response
    } WriteState_t;

    WriteState_t              state;
    WriteState_t              nextState;
    AxiLiteRegPkg::WriteReq_t request;
    AxiLiteRegPkg::Resp_t     response;

    always_ff @(posedge ACLK) begin
        if (!ARESETN) begin
            state <= Idle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            Idle: begin
                if (AWVALID && WVALID) begin
                    nextState = Request;
                end
            end
            Request: begin
                if (writeAck) begin
                    nextState = Response;
                end
            end
            Response: begin
                if (BREADY) begin
                    nextState = Idle;
                end
            end
            default: nextState = Idle;
        endcase
    end

    // Address, data and strobe are taken together. The byte address becomes a word index.
    always_ff @(posedge ACLK) begin
        if (state == Idle && AWVALID && WVALID) begin
            request.wordAddr <= {2'b00, AWADDR[AxiLiteRegPkg::AddrWidth-1:2]};
            request.data     <= WDATA;
            request.strobe   <= WSTRB;
        end
    end

    always_ff @(posedge ACLK) begin
        if (state == Request && writeAck) begin
            response <= writeResp;
        end
    end

    // Both ready signals close the handshake once the bank has taken the write.
    assign AWREADY    = (state == Request) && writeAck;
    assign WREADY     = (state == Request) && writeAck;
    assign writeValid = (state == Request);
    assign writeReq   = request;
    assign BVALID     = (state == Response);
    assign BRESP      = response;

endmodule

`default_nettype wire

//--- source/RegisterBank.sv
`timescale 1ns/1ns
`default_nettype none

module RegisterBank #(
    parameter int NumRegisters = 8
) (
    input  wire logic                                   ACLK,
    input  wire logic                                   ARESETN,
    input  wire AxiLiteRegPkg::WriteReq_t               writeReq,
    input  wire logic                                   writeValid,
    output logic                                        writeAck,
    output AxiLiteRegPkg::Resp_t                        writeResp,
    input  wire logic [AxiLiteRegPkg::AddrWidth-1:0]    readAddr,
    input  wire logic                                   readValid,
    output AxiLiteRegPkg::ReadRsp_t                     readRsp
);

    // The address map holds at most 64 words.
    if (NumRegisters < 2 || NumRegisters > 64) begin : gSizeCheck
        $error("NumRegisters must lie between 2 and 64");
    end

    // Register 0 is the fixed identification word and has no storage.
    logic [AxiLiteRegPkg::DataWidth-1:0] regFile [1:NumRegisters-1];
    logic                                writable;

    assign writable  = (writeReq.wordAddr != '0) && (int'(writeReq.wordAddr) < NumRegisters);
    assign writeAck  = writeValid;
    assign writeResp = writable ? AxiLiteRegPkg::Okay : AxiLiteRegPkg::SlvErr;

    always_ff @(posedge ACLK) begin
        if (!ARESETN) begin
            for (int i = 1; i < NumRegisters; i++) begin
                regFile[i] <= '0;
            end
        end else if (writeValid && writable) begin
            for (int i = 1; i < NumRegisters; i++) begin
                if (int'(writeReq.wordAddr) == i) begin
                    // Only the byte lanes enabled by the strobe change.
                    for (int b = 0; b < AxiLiteRegPkg::StrbWidth; b++) begin
                        if (writeReq.strobe[b]) begin
                            regFile[i][8*b +: 8] <= writeReq.data[8*b +: 8];
                        end
                    end
                end
            end
        end
    end

    // Reads see the contents before any write on the same edge.
    always_comb begin
        readRsp.data = '0;
        readRsp.resp = AxiLiteRegPkg::Okay;
        if (readValid) begin
            if (int'(readAddr) >= NumRegisters) begin
                readRsp.resp = AxiLiteRegPkg::SlvErr;
            end else if (readAddr == '0) begin
                readRsp.data = AxiLiteRegPkg::IdValue;
            end else begin
                for (int i = 1; i < NumRegisters; i++) begin
                    if (int'(readAddr) == i) begin
                        readRsp.data = regFile[i];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- source/AxiLiteReadChannel.sv
`timescale 1ns/1ns
`default_nettype none

module AxiLiteReadChannel (
    input  wire logic                                   ACLK,
    input  wire logic                                   ARESETN,
    input  wire logic                                   ARVALID,
    output logic                                        ARREADY,
    input  wire logic [AxiLiteRegPkg::AddrWidth-1:0]    ARADDR,
    input  wire logic [2:0]                             ARPROT,
    output logic                                        RVALID,
    input  wire logic                                   RREADY,
    output logic [AxiLiteRegPkg::DataWidth-1:0]         RDATA,
    output logic [1:0]                                  RRESP,
    output logic [AxiLiteRegPkg::AddrWidth-1:0]         readAddr,
    output logic                                        readValid,
    input  wire AxiLiteRegPkg::ReadRsp_t                readRsp
);

    typedef enum logic [1:0] {
        Idle,
        Fetch,
        Data
    } ReadState_t;

    ReadState_t                          state;
    ReadState_t                          nextState;
    logic [AxiLiteRegPkg::AddrWidth-1:0] wordAddr;
    AxiLiteRegPkg::ReadRsp_t             response;

    always_ff @(posedge ACLK) begin
        if (!ARESETN) begin
            state <= Idle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            Idle: begin
                if (ARVALID) begin
                    nextState = Fetch;
                end
            end
            Fetch: nextState = Data;
            Data: begin
                if (RREADY) begin
                    nextState = Idle;
                end
            end
            default: nextState = Idle;
        endcase
    end

    always_ff @(posedge ACLK) begin
        if (state == Idle && ARVALID) begin
            wordAddr <= {2'b00, ARADDR[AxiLiteRegPkg::AddrWidth-1:2]};
        end
    end

    // The bank's answer is held here until the master takes it.
    always_ff @(posedge ACLK) begin
        if (state == Fetch) begin
            response <= readRsp;
        end
    end

    assign ARREADY   = (state == Idle);
    assign readAddr  = wordAddr;
    assign readValid = (state == Fetch);
    assign RVALID    = (state == Data);
    assign RDATA     = response.data;
    assign RRESP     = response.resp;

endmodule

`default_nettype wire

//--- source/AxiLiteRegisterSlave.sv
`timescale 1ns/1ns
`default_nettype none

module AxiLiteRegisterSlave #(
    parameter int NumRegisters = 8
) (
    input  wire logic                                   ACLK,
    input  wire logic                                   ARESETN,
    input  wire logic                                   AWVALID,
    output logic                                        AWREADY,
    input  wire logic [AxiLiteRegPkg::AddrWidth-1:0]    AWADDR,
    input  wire logic [2:0]                             AWPROT,
    input  wire logic                                   WVALID,
    output logic                                        WREADY,
    input  wire logic [AxiLiteRegPkg::DataWidth-1:0]    WDATA,
    input  wire logic [AxiLiteRegPkg::StrbWidth-1:0]    WSTRB,
    output logic                                        BVALID,
    input  wire logic                                   BREADY,
    output logic [1:0]                                  BRESP,
    input  wire logic                                   ARVALID,
    output logic                                        ARREADY,
    input  wire logic [AxiLiteRegPkg::AddrWidth-1:0]    ARADDR,
    input  wire logic [2:0]                             ARPROT,
    output logic                                        RVALID,
    input  wire logic                                   RREADY,
    output logic [AxiLiteRegPkg::DataWidth-1:0]         RDATA,
    output logic [1:0]                                  RRESP
);

    AxiLiteRegPkg::WriteReq_t            writeReq;
    logic                                writeValid;
    logic                                writeAck;
    AxiLiteRegPkg::Resp_t                writeResp;
    logic [AxiLiteRegPkg::AddrWidth-1:0] readAddr;
    logic                                readValid;
    AxiLiteRegPkg::ReadRsp_t             readRsp;

    AxiLiteWriteChannel writeChannel_i (
        .ACLK       (ACLK),
        .ARESETN    (ARESETN),
        .AWVALID    (AWVALID),
        .AWREADY    (AWREADY),
        .AWADDR     (AWADDR),
        .AWPROT     (AWPROT),
        .WVALID     (WVALID),
        .WREADY     (WREADY),
        .WDATA      (WDATA),
        .WSTRB      (WSTRB),
        .BVALID     (BVALID),
        .BREADY     (BREADY),
        .BRESP      (BRESP),
        .writeReq   (writeReq),
        .writeValid (writeValid),
        .writeAck   (writeAck),
        .writeResp  (writeResp)
    );

    RegisterBank #(
        .NumRegisters (NumRegisters)
    ) registerBank_i (
        .ACLK       (ACLK),
        .ARESETN    (ARESETN),
        .writeReq   (writeReq),
        .writeValid (writeValid),
        .writeAck   (writeAck),
        .writeResp  (writeResp),
        .readAddr   (readAddr),
        .readValid  (readValid),
        .readRsp    (readRsp)
    );

    AxiLiteReadChannel readChannel_i (
        .ACLK      (ACLK),
        .ARESETN   (ARESETN),
        .ARVALID   (ARVALID),
        .ARREADY   (ARREADY),
        .ARADDR    (ARADDR),
        .ARPROT    (ARPROT),
        .RVALID    (RVALID),
        .RREADY    (RREADY),
        .RDATA     (RDATA),
        .RRESP     (RRESP),
        .readAddr  (readAddr),
        .readValid (readValid),
        .readRsp   (readRsp)
    );

endmodule

`default_nettype wire

//--- sim/AxiLiteRegisterSlave_properties.sv
`timescale 1ns/1ns
`default_nettype none

module AxiLiteRegisterSlave_properties (
    input wire logic        ACLK,
    input wire logic        ARESETN,
    input wire logic        AWREADY,
    input wire logic        WREADY,
    input wire logic        BVALID,
    input wire logic        BREADY,
    input wire logic [1:0]  BRESP,
    input wire logic        RVALID,
    input wire logic        RREADY,
    input wire logic [31:0] RDATA,
    input wire logic [1:0]  RRESP
);

    // A response beat holds with its payload until the master takes it.
    bHeld: assert property (@(posedge ACLK) disable iff (!ARESETN)
        BVALID && !BREADY |=> BVALID && $stable(BRESP))
        else $error("BVALID or BRESP changed before BREADY");

    rHeld: assert property (@(posedge ACLK) disable iff (!ARESETN)
        RVALID && !RREADY |=> RVALID && $stable(RDATA) && $stable(RRESP))
        else $error("RVALID, RDATA or RRESP changed before RREADY");

    readyPair: assert property (@(posedge ACLK) disable iff (!ARESETN) AWREADY == WREADY)
        else $error("AWREADY and WREADY differ");

    resetQuiet: assert property (@(posedge ACLK) !ARESETN |=> !BVALID && !RVALID)
        else $error("Response valid high right after reset");

endmodule

bind AxiLiteRegisterSlave AxiLiteRegisterSlave_properties properties_i (
    .ACLK    (ACLK),
    .ARESETN (ARESETN),
    .AWREADY (AWREADY),
    .WREADY  (WREADY),
    .BVALID  (BVALID),
    .BREADY  (BREADY),
    .BRESP   (BRESP),
    .RVALID  (RVALID),
    .RREADY  (RREADY),
    .RDATA   (RDATA),
    .RRESP   (RRESP)
);

`default_nettype wire

//--- sim/AxiLiteRegisterSlaveTb.sv
`timescale 1ns/1ns
`default_nettype none

module AxiLiteRegisterSlaveTb;

    localparam int         NumRegs       = 8;
    localparam int         TimeoutCycles = 50;
    localparam logic [1:0] OkayCode      = 2'b00;
    localparam logic [1:0] SlvErrCode    = 2'b10;

    logic        ACLK = 1'b0;
    logic        ARESETN;
    logic        AWVALID;
    logic        AWREADY;
    logic [7:0]  AWADDR;
    logic [2:0]  AWPROT;
    logic        WVALID;
    logic        WREADY;
    logic [31:0] WDATA;
    logic [3:0]  WSTRB;
    logic        BVALID;
    logic        BREADY;
    logic [1:0]  BRESP;
    logic        ARVALID;
    logic        ARREADY;
    logic [7:0]  ARADDR;
    logic [2:0]  ARPROT;
    logic        RVALID;
    logic        RREADY;
    logic [31:0] RDATA;
    logic [1:0]  RRESP;

    // Expected register contents from word 1 upward.
    logic [31:0] model [1:NumRegs-1];
    logic [1:0]  expB [$];
    logic [33:0] expR [$];
    int          errorCount = 0;
    int          checkCount = 0;
    int          testBase   = 0;

    always #50 ACLK = ~ACLK;

    AxiLiteRegisterSlave #(.NumRegisters(NumRegs)) dut_i (.*);

    task automatic noteFailure(input string what);
        errorCount++;
        $display("%s at %0t", what, $time);
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        errorCount++;
        $display("ERR %0t %s expected %0h got %0h", $time, name, expected, actual);
    endtask

    task automatic abortRun(input string what);
        $display("Timeout: %s at %0t", what, $time);
        $display(">>> FAIL");
        $finish;
    endtask

    task automatic endTest(input int number, input string name);
        $display("Test %0d (%s) finished with %0d errors", number, name, errorCount - testBase);
        testBase = errorCount;
    endtask

    // Applies an access to the expected contents and gives the expected answer.
    function automatic void refModel(input logic isWrite, input logic [7:0] addr,
                                     input logic [31:0] data, input logic [3:0] strb,
                                     output logic [31:0] expData, output logic [1:0] expResp);
        int index;
        index   = int'(addr[7:2]);
        expData = '0;
        expResp = OkayCode;
        if (isWrite) begin
            if (index == 0 || index >= NumRegs) begin
                expResp = SlvErrCode;
            end else begin
                for (int b = 0; b < 4; b++) begin
                    if (strb[b]) begin
                        model[index][8*b +: 8] = data[8*b +: 8];
                    end
                end
            end
        end else if (index >= NumRegs) begin
            expResp = SlvErrCode;
        end else if (index == 0) begin
            expData = AxiLiteRegPkg::IdValue;
        end else begin
            expData = model[index];
        end
    endfunction

    task automatic writeBus(input logic [7:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input int holdCycles, output int readyDelay);
        logic [31:0] expData;
        logic [1:0]  expResp;
        logic [1:0]  heldResp;
        int          waitCount;
        refModel(1'b1, addr, data, strb, expData, expResp);
        expB.push_back(expResp);
        @(posedge ACLK);
        AWVALID <= 1'b1;
        AWADDR  <= addr;
        WVALID  <= 1'b1;
        WDATA   <= data;
        WSTRB   <= strb;
        readyDelay = 0;
        @(negedge ACLK);
        while (!AWREADY) begin
            readyDelay++;
            if (readyDelay > TimeoutCycles) begin
                abortRun("AWREADY never rose");
            end
            @(negedge ACLK);
        end
        assert (WREADY) else reportMismatch("WREADY", 32'd1, 32'(WREADY));
        @(posedge ACLK);
        AWVALID <= 1'b0;
        WVALID  <= 1'b0;
        waitCount = 0;
        @(negedge ACLK);
        while (!BVALID) begin
            waitCount++;
            if (waitCount > TimeoutCycles) begin
                abortRun("BVALID never rose");
            end
            @(negedge ACLK);
        end
        heldResp = BRESP;
        repeat (holdCycles) begin
            @(negedge ACLK);
            assert (BVALID && BRESP == heldResp)
                else noteFailure("Write response moved while BREADY was low");
        end
        @(posedge ACLK);
        BREADY <= 1'b1;
        @(posedge ACLK);
        BREADY <= 1'b0;
    endtask

    task automatic readBus(input logic [7:0] addr, input int holdCycles);
        logic [31:0] expData;
        logic [1:0]  expResp;
        logic [33:0] heldBeat;
        int          waitCount;
        refModel(1'b0, addr, '0, '0, expData, expResp);
        expR.push_back({expData, expResp});
        @(posedge ACLK);
        ARVALID <= 1'b1;
        ARADDR  <= addr;
        waitCount = 0;
        @(negedge ACLK);
        while (!ARREADY) begin
            waitCount++;
            if (waitCount > TimeoutCycles) begin
                abortRun("ARREADY never rose");
            end
            @(negedge ACLK);
        end
        @(posedge ACLK);
        ARVALID <= 1'b0;
        waitCount = 0;
        @(negedge ACLK);
        while (!RVALID) begin
            waitCount++;
            if (waitCount > TimeoutCycles) begin
                abortRun("RVALID never rose");
            end
            @(negedge ACLK);
        end
        heldBeat = {RDATA, RRESP};
        repeat (holdCycles) begin
            @(negedge ACLK);
            assert (RVALID && {RDATA, RRESP} == heldBeat)
                else noteFailure("Read data moved while RREADY was low");
        end
        @(posedge ACLK);
        RREADY <= 1'b1;
        @(posedge ACLK);
        RREADY <= 1'b0;
    endtask

    // Each B and R beat is checked on the falling edge before its handshake.
    always @(negedge ACLK) begin
        logic [33:0] beat;
        if (ARESETN && BVALID && BREADY) begin
            checkCount++;
            if (expB.size() == 0) begin
                noteFailure("Write response arrived with no write pending");
            end else begin
                beat[1:0] = expB.pop_front();
                assert (BRESP == beat[1:0])
                    else reportMismatch("BRESP", 32'(beat[1:0]), 32'(BRESP));
            end
        end
        if (ARESETN && RVALID && RREADY) begin
            checkCount++;
            if (expR.size() == 0) begin
                noteFailure("Read data arrived with no read pending");
            end else begin
                beat = expR.pop_front();
                assert (RDATA == beat[33:2]) else reportMismatch("RDATA", beat[33:2], RDATA);
                assert (RRESP == beat[1:0])
                    else reportMismatch("RRESP", 32'(beat[1:0]), 32'(RRESP));
            end
        end
    end

    initial begin
        int seedValue;
        int delay;
        int index;
        seedValue = $urandom(43);
        ARESETN <= 1'b0;
        AWVALID <= 1'b0;
        AWADDR  <= '0;
        AWPROT  <= '0;
        WVALID  <= 1'b0;
        WDATA   <= '0;
        WSTRB   <= '0;
        BREADY  <= 1'b0;
        ARVALID <= 1'b0;
        ARADDR  <= '0;
        ARPROT  <= '0;
        RREADY  <= 1'b0;
        for (index = 1; index < NumRegs; index++) begin
            model[index] = '0;
        end
        repeat (10) @(posedge ACLK);
        ARESETN <= 1'b1;

        for (index = 0; index < NumRegs; index++) begin
            readBus(8'(index * 4), 0);
        end
        endTest(1, "reset values");

        for (index = 1; index < NumRegs; index++) begin
            writeBus(8'(index * 4), $urandom(), 4'hF, 0, delay);
            assert (delay == 1) else reportMismatch("AWREADY delay", 32'd1, 32'(delay));
            readBus(8'(index * 4), 0);
        end
        endTest(2, "full strobe writes");

        repeat (30) begin
            index = $urandom_range(1, NumRegs - 1);
            writeBus(8'(index * 4), $urandom(), 4'($urandom_range(0, 15)), 0, delay);
            readBus(8'(index * 4), 0);
        end
        endTest(3, "partial strobe writes");

        writeBus(8'h00, $urandom(), 4'hF, 0, delay);
        writeBus(8'(NumRegs * 4), $urandom(), 4'hF, 0, delay);
        writeBus(8'hFC, $urandom(), 4'hF, 0, delay);
        for (index = 0; index < NumRegs; index++) begin
            readBus(8'(index * 4), 0);
        end
        readBus(8'(NumRegs * 4), 0);
        readBus(8'hFC, 0);
        endTest(4, "error responses");

        repeat (10) begin
            index = $urandom_range(1, NumRegs - 1);
            writeBus(8'(index * 4), $urandom(), 4'hF, $urandom_range(1, 8), delay);
            readBus(8'(index * 4), $urandom_range(1, 8));
            readBus(8'(index * 4), 0);
        end
        endTest(5, "back-pressure");

        repeat (200) begin
            index = $urandom_range(0, NumRegs + 1);
            if ($urandom_range(0, 1) == 1) begin
                writeBus(8'(index * 4), $urandom(), 4'($urandom_range(0, 15)),
                         $urandom_range(0, 3), delay);
            end else begin
                readBus(8'(index * 4), $urandom_range(0, 3));
            end
        end
        endTest(6, "random mix");

        $display("Checked %0d beats, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
source/AxiLiteRegPkg.sv
source/AxiLiteWriteChannel.sv
source/RegisterBank.sv
source/AxiLiteReadChannel.sv
source/AxiLiteRegisterSlave.sv
sim/AxiLiteRegisterSlave_properties.sv
sim/AxiLiteRegisterSlaveTb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f build.f --top-module AxiLiteRegisterSlaveTb \
    -o simv > build.log 2>&1 || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/simv > sim.log 2>&1 || echo "Simulator exited with an error"
cat sim.log
grep -qx ">>> PASS" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
